/* scaler_lite.f */
src/scaler_pkg.sv
src/input_capture.sv
src/line_buffer.sv
src/output_timing.sv
src/pixel_fetch.sv
src/scaler_top.sv
testbench/tb_scaler.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_scaler
FILELIST  ?= scaler_lite.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG) || { echo "simulation failed"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/tb_scaler.sv */
`timescale 1ns/1ps

module tb_scaler;

  localparam int HREP     = scaler_pkg::HREP_D;
  localparam int VREP     = scaler_pkg::VREP_D;
  localparam int H_ACTIVE = scaler_pkg::IN_HACTIVE_D * HREP;
  localparam int V_ACTIVE = scaler_pkg::IN_VACTIVE_D * VREP;
  localparam int H_TOTAL  = scaler_pkg::H_SYNC_D + scaler_pkg::H_BACK_D + H_ACTIVE +
                            scaler_pkg::H_FRONT_D;
  localparam int V_TOTAL  = scaler_pkg::V_SYNC_D + scaler_pkg::V_BACK_D + V_ACTIVE +
                            scaler_pkg::V_FRONT_D;
  localparam int DE_DELAY = scaler_pkg::H_SYNC_D + scaler_pkg::H_BACK_D;
  localparam int WIN_LAST = scaler_pkg::IN_HSTART_D + scaler_pkg::IN_HACTIVE_D - 1;
  localparam int WIN_VEND = scaler_pkg::IN_VSTART_D + scaler_pkg::IN_VACTIVE_D;

  // source raster, one input line spans several output lines
  localparam int IN_LINE      = 160;
  localparam int IN_LINES     = 14;
  localparam int NHS_LEN      = 4;
  localparam int NVS_LINES    = 2;
  localparam int FRAMES       = 3;
  localparam int RESYNC_FRAME = 1;
  localparam int RESYNC_LINE  = 4;   // ahead of the trigger line, restart waits a frame
  localparam int SETTLE       = 10;  // last window pixel to a safe page latch
  localparam int WATCHDOG_CYC = FRAMES * IN_LINES * IN_LINE * 2 + 4000;

  logic                  vclk;
  logic                  nrst;
  scaler_pkg::video_in_t vdata_in;
  logic                  vdata_valid;
  logic                  nresync;
  logic                  hsync;
  logic                  vsync;
  logic                  de;
  scaler_pkg::pixel_t    vdata_out;

  integer seed = 32'h493674ac;
  int cyc = 0;
  logic expect_idle = 1'b1;  // outputs must stay zero
  int idle_from = 0;
  logic armed = 1'b0;
  logic [11:0] line_no = 12'd1;
  logic [11:0] done_id = '0;        // latest fully captured line
  logic [11:0] prev_done_id = '0;
  int done_cyc = 0;

  // checker state
  logic seen_hs = 1'b0;
  logic seen_vs = 1'b0;
  logic hs_q = 1'b0;
  logic de_q = 1'b0;
  logic vs_line_q = 1'b0;
  int since_hs = 0;
  int hs_len = 0;
  int lines = 0;
  int vs_lines = 0;
  int de_lines = 0;
  int col = 0;
  logic [11:0] line_id = '0;
  logic [11:0] grp_id = '0;
  int frames = 0;
  int starts = 0;

  scaler_top u_dut (
    .VCLK_i           (vclk),
    .nRST_i           (nrst),
    .vdata_i          (vdata_in),
    .vdata_valid_i    (vdata_valid),
    .scaler_nresync_i (nresync),
    .HSYNC_o          (hsync),
    .VSYNC_o          (vsync),
    .DE_o             (de),
    .vdata_o          (vdata_out)
  );

  task automatic stop_run(input string msg);
    $display("error: %s at %0t", msg, $time);
    $display("=== FAIL ===");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic flag_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("Fail %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    $display("=== FAIL ===");
    $fatal(1, "stopped at the first error");
  endtask

  // one valid sample, after a random number of stall cycles
  task automatic drive_sample(input logic nvs, input logic nhs, input scaler_pkg::pixel_t px);
    @(negedge vclk);
    while (($random(seed) & 3) == 0) begin
      vdata_valid = 1'b0;
      @(negedge vclk);
    end
    vdata_in    = '{nvs: nvs, nhs: nhs, pixel: px};
    vdata_valid = 1'b1;
  endtask

  task automatic pulse_resync();
    @(negedge vclk);
    vdata_valid = 1'b0;
    nresync     = 1'b0;
    expect_idle <= 1'b1;
    armed       <= 1'b0;
    idle_from   <= cyc + 3;  // dark within 3 cycles
    repeat (3) @(negedge vclk);
    nresync = 1'b1;
  endtask

  initial begin : clock_gen
    vclk = 1'b0;
    forever #5 vclk = ~vclk;
  end

  always @(posedge vclk) cyc <= cyc + 1;

  initial begin : watchdog
    repeat (WATCHDOG_CYC) @(posedge vclk);
    $display("timeout: run did not end within %0d cycles", WATCHDOG_CYC);
    $display("=== FAIL ===");
    $fatal(1, "watchdog expired");
  end

  // blanking carries no pixel data
  assert property (@(posedge vclk) !de |-> vdata_out == '0)
    else flag_mismatch("vdata_o", 32'(vdata_out), 32'h0);

  assert property (@(posedge vclk) !nrst |-> !(hsync || vsync || de))
    else stop_run("sync outputs active during reset");

  always @(negedge vclk) begin : check_outputs
    logic [11:0] id;
    id = vdata_out[23:12];
    if (expect_idle) begin
      if (cyc >= idle_from) begin
        assert (!hsync) else flag_mismatch("HSYNC_o", 32'(hsync), 32'h0);
        assert (!vsync) else flag_mismatch("VSYNC_o", 32'(vsync), 32'h0);
        assert (!de) else flag_mismatch("DE_o", 32'(de), 32'h0);
        assert (vdata_out == '0) else flag_mismatch("vdata_o", 32'(vdata_out), 32'h0);
      end
      seen_hs   = 1'b0;
      seen_vs   = 1'b0;
      hs_q      = 1'b0;
      de_q      = 1'b0;
      vs_line_q = 1'b0;
      hs_len    = 0;
      de_lines  = 0;
    end else begin
      since_hs = since_hs + 1;
      if (hsync && !hs_q) begin
        if (seen_hs) begin
          assert (since_hs == H_TOTAL) else flag_mismatch("HSYNC_o period", since_hs, H_TOTAL);
        end else begin
          starts = starts + 1;  // first line after a (re)start
        end
        seen_hs  = 1'b1;
        since_hs = 0;
        hs_len   = 0;
        if (vsync && !vs_line_q) begin
          if (seen_vs) begin
            assert (lines == V_TOTAL) else flag_mismatch("VSYNC_o period", lines, V_TOTAL);
            assert (de_lines == V_ACTIVE) else flag_mismatch("DE_o lines", de_lines, V_ACTIVE);
            frames = frames + 1;
          end
          seen_vs  = 1'b1;
          lines    = 0;
          vs_lines = 0;
          de_lines = 0;
        end
        if (!vsync && vs_line_q)
          assert (vs_lines == scaler_pkg::V_SYNC_D)
            else flag_mismatch("VSYNC_o width", vs_lines, scaler_pkg::V_SYNC_D);
        if (vsync)
          vs_lines = vs_lines + 1;
        lines     = lines + 1;
        vs_line_q = vsync;
      end
      if (hsync)
        hs_len = hs_len + 1;
      if (!hsync && hs_q && seen_hs)
        assert (hs_len == scaler_pkg::H_SYNC_D)
          else flag_mismatch("HSYNC_o width", hs_len, scaler_pkg::H_SYNC_D);

      if (de && !de_q) begin
        assert (since_hs == DE_DELAY) else flag_mismatch("DE_o start", since_hs, DE_DELAY);
        col     = 0;
        line_id = id;
        if (de_lines % VREP == 0) begin
          // new repeat group shows the newest complete input line
          if (cyc - done_cyc >= SETTLE) begin
            assert (id == done_id) else flag_mismatch("vdata_o line id", id, done_id);
          end else begin
            assert (id == done_id || id == prev_done_id)
              else flag_mismatch("vdata_o line id", id, done_id);
          end
          grp_id = id;
        end else begin
          assert (id == grp_id) else flag_mismatch("vdata_o group id", id, grp_id);
        end
        de_lines = de_lines + 1;
      end
      if (de) begin
        assert (vdata_out[11:0] == 12'(col / HREP))
          else flag_mismatch("vdata_o column", 32'(vdata_out[11:0]), col / HREP);
        assert (id == line_id) else flag_mismatch("vdata_o line id", id, line_id);
        col = col + 1;
      end
      if (!de && de_q)
        assert (col == H_ACTIVE) else flag_mismatch("DE_o width", col, H_ACTIVE);
      hs_q = hsync;
      de_q = de;
    end
  end

  initial begin : stimulus
    int f;
    int l;
    int s;
    nrst        = 1'b0;
    vdata_in    = '0;
    vdata_valid = 1'b0;
    nresync     = 1'b1;
    repeat (8) @(negedge vclk);
    nrst = 1'b1;
    repeat (8) drive_sample(1'b1, 1'b1, '0);  // idle so the first sync edges count
    for (f = 0; f < FRAMES; f++) begin
      for (l = 0; l < IN_LINES; l++) begin
        if (f == RESYNC_FRAME && l == RESYNC_LINE)
          pulse_resync();
        for (s = 0; s < IN_LINE; s++) begin
          drive_sample(l >= NVS_LINES, s >= NHS_LEN,
                       {line_no, 12'(s - scaler_pkg::IN_HSTART_D)});
          if (l == 0 && s == 0)
            armed <= 1'b1;  // frame start
          if (l == scaler_pkg::TRIG_LINES_D && s == 0 && armed)
            expect_idle <= 1'b0;
          if (l >= scaler_pkg::IN_VSTART_D && l < WIN_VEND && s == WIN_LAST) begin
            prev_done_id <= done_id;
            done_id      <= line_no;
            done_cyc     <= cyc;
          end
        end
        line_no = line_no + 1'b1;
      end
    end
    vdata_valid = 1'b0;
    repeat (3 * H_TOTAL) @(negedge vclk);
    if (starts < 2 || frames < 2) begin
      $display("error: too little output seen, %0d starts and %0d frames", starts, frames);
      $display("=== FAIL ===");
      $fatal(1, "incomplete run");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

/* src/scaler_top.sv */
`timescale 1ns/1ps

module scaler_top #(
  parameter int IN_HSTART  = scaler_pkg::IN_HSTART_D,
  parameter int IN_HACTIVE = scaler_pkg::IN_HACTIVE_D,
  parameter int IN_VSTART  = scaler_pkg::IN_VSTART_D,
  parameter int IN_VACTIVE = scaler_pkg::IN_VACTIVE_D,
  parameter int TRIG_LINES = scaler_pkg::TRIG_LINES_D,
  parameter int HREP       = scaler_pkg::HREP_D,
  parameter int VREP       = scaler_pkg::VREP_D,
  parameter int H_SYNC     = scaler_pkg::H_SYNC_D,
  parameter int H_BACK     = scaler_pkg::H_BACK_D,
  parameter int H_FRONT    = scaler_pkg::H_FRONT_D,
  parameter int V_SYNC     = scaler_pkg::V_SYNC_D,
  parameter int V_BACK     = scaler_pkg::V_BACK_D,
  parameter int V_FRONT    = scaler_pkg::V_FRONT_D
) (
  input  logic                  VCLK_i,
  input  logic                  nRST_i,
  input  scaler_pkg::video_in_t vdata_i,
  input  logic                  vdata_valid_i,
  input  logic                  scaler_nresync_i,
  output logic                  HSYNC_o,
  output logic                  VSYNC_o,
  output logic                  DE_o,
  output scaler_pkg::pixel_t    vdata_o
);

  // output active area is the input window scaled up
  localparam int H_ACTIVE = IN_HACTIVE * HREP;
  localparam int V_ACTIVE = IN_VACTIVE * VREP;

  scaler_pkg::buf_wr_t   buf_wr;
  scaler_pkg::page_t     last_page;
  scaler_pkg::page_t     rd_page;
  scaler_pkg::buf_addr_t rd_addr;
  scaler_pkg::pixel_t    rd_data;
  logic                  run;
  scaler_pkg::cnt_t      hcnt;
  scaler_pkg::cnt_t      vcnt;
  scaler_pkg::sync_t     raster;

  input_capture #(
    .IN_HSTART  (IN_HSTART),
    .IN_HACTIVE (IN_HACTIVE),
    .IN_VSTART  (IN_VSTART),
    .IN_VACTIVE (IN_VACTIVE),
    .TRIG_LINES (TRIG_LINES)
  ) u_capture (
    .VCLK_i           (VCLK_i),
    .nRST_i           (nRST_i),
    .vdata_i          (vdata_i),
    .vdata_valid_i    (vdata_valid_i),
    .scaler_nresync_i (scaler_nresync_i),
    .rd_page_i        (rd_page),
    .buf_wr_o         (buf_wr),
    .last_page_o      (last_page),
    .run_o            (run)
  );

  line_buffer u_buffer (
    .VCLK_i    (VCLK_i),
    .buf_wr_i  (buf_wr),
    .rd_page_i (rd_page),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data)
  );

  output_timing #(
    .H_ACTIVE (H_ACTIVE),
    .V_ACTIVE (V_ACTIVE),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .H_FRONT  (H_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK),
    .V_FRONT  (V_FRONT)
  ) u_timing (
    .VCLK_i (VCLK_i),
    .nRST_i (nRST_i),
    .run_i  (run),
    .hcnt_o (hcnt),
    .vcnt_o (vcnt),
    .sync_o (raster)
  );

  pixel_fetch #(
    .HREP     (HREP),
    .VREP     (VREP),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .H_ACTIVE (H_ACTIVE),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK),
    .V_ACTIVE (V_ACTIVE)
  ) u_fetch (
    .VCLK_i      (VCLK_i),
    .nRST_i      (nRST_i),
    .hcnt_i      (hcnt),
    .vcnt_i      (vcnt),
    .sync_i      (raster),
    .last_page_i (last_page),
    .rd_data_i   (rd_data),
    .rd_page_o   (rd_page),
    .rd_addr_o   (rd_addr),
    .HSYNC_o     (HSYNC_o),
    .VSYNC_o     (VSYNC_o),
    .DE_o        (DE_o),
    .vdata_o     (vdata_o)
  );

endmodule

/* src/pixel_fetch.sv */
`timescale 1ns/1ps

module pixel_fetch #(
  parameter int HREP     = scaler_pkg::HREP_D,
  parameter int VREP     = scaler_pkg::VREP_D,
  parameter int H_SYNC   = scaler_pkg::H_SYNC_D,
  parameter int H_BACK   = scaler_pkg::H_BACK_D,
  parameter int H_ACTIVE = scaler_pkg::IN_HACTIVE_D * scaler_pkg::HREP_D,
  parameter int V_SYNC   = scaler_pkg::V_SYNC_D,
  parameter int V_BACK   = scaler_pkg::V_BACK_D,
  parameter int V_ACTIVE = scaler_pkg::IN_VACTIVE_D * scaler_pkg::VREP_D
) (
  input  logic                  VCLK_i,
  input  logic                  nRST_i,
  input  scaler_pkg::cnt_t      hcnt_i,
  input  scaler_pkg::cnt_t      vcnt_i,
  input  scaler_pkg::sync_t     sync_i,
  input  scaler_pkg::page_t     last_page_i,
  input  scaler_pkg::pixel_t    rd_data_i,
  output scaler_pkg::page_t     rd_page_o,
  output scaler_pkg::buf_addr_t rd_addr_o,
  output logic                  HSYNC_o,
  output logic                  VSYNC_o,
  output logic                  DE_o,
  output scaler_pkg::pixel_t    vdata_o
);

  localparam scaler_pkg::cnt_t H_START = scaler_pkg::cnt_t'(H_SYNC + H_BACK);
  localparam scaler_pkg::cnt_t H_LOAD  = scaler_pkg::cnt_t'(H_SYNC + H_BACK - 1);
  localparam scaler_pkg::cnt_t H_LAST  = scaler_pkg::cnt_t'(H_SYNC + H_BACK + H_ACTIVE - 1);
  localparam scaler_pkg::cnt_t V_START = scaler_pkg::cnt_t'(V_SYNC + V_BACK);
  localparam scaler_pkg::cnt_t V_STOP  = scaler_pkg::cnt_t'(V_SYNC + V_BACK + V_ACTIVE);
  localparam scaler_pkg::cnt_t HREP_LAST = scaler_pkg::cnt_t'(HREP - 1);
  localparam scaler_pkg::cnt_t VREP_LAST = scaler_pkg::cnt_t'(VREP - 1);

  logic h_act;
  logic v_act;
  scaler_pkg::cnt_t hrep_q;  // repeats of the current pixel
  scaler_pkg::cnt_t vrep_q;  // repeats of the current buffered line
  scaler_pkg::sync_t sync_q;

  assign h_act = (hcnt_i >= H_START) && (hcnt_i <= H_LAST);
  assign v_act = (vcnt_i >= V_START) && (vcnt_i < V_STOP);

  // rd_addr_o always belongs to the column now on hcnt_i
  always_ff @(posedge VCLK_i or negedge nRST_i) begin
    if (!nRST_i) begin
      rd_addr_o <= '0;
      hrep_q    <= '0;
    end else if (hcnt_i == H_LOAD) begin
      rd_addr_o <= '0;
      hrep_q    <= '0;
    end else if (h_act) begin
      if (hrep_q == HREP_LAST) begin
        rd_addr_o <= rd_addr_o + 1'b1;
        hrep_q    <= '0;
      end else begin
        hrep_q <= hrep_q + 1'b1;
      end
    end
  end

  always_ff @(posedge VCLK_i or negedge nRST_i) begin
    if (!nRST_i) begin
      vrep_q    <= '0;
      rd_page_o <= '0;
    end else if (!v_act) begin
      vrep_q <= '0;
    end else begin
      // new source line only at the start of a repeat group
      if (hcnt_i == H_LOAD && vrep_q == '0)
        rd_page_o <= last_page_i;
      if (hcnt_i == H_LAST)
        vrep_q <= (vrep_q == VREP_LAST) ? '0 : vrep_q + 1'b1;
    end
  end

  // rd_data_i lines up with sync_i, both one cycle after the counters
  always_ff @(posedge VCLK_i or negedge nRST_i) begin
    if (!nRST_i) begin
      sync_q  <= '0;
      vdata_o <= '0;
    end else begin
      sync_q  <= sync_i;
      vdata_o <= sync_i.de ? rd_data_i : '0;  // blank outside DE
    end
  end

  assign HSYNC_o = sync_q.hsync;
  assign VSYNC_o = sync_q.vsync;
  assign DE_o    = sync_q.de;

endmodule

/* src/output_timing.sv */
`timescale 1ns/1ps

module output_timing #(
  parameter int H_ACTIVE = scaler_pkg::IN_HACTIVE_D * scaler_pkg::HREP_D,
  parameter int V_ACTIVE = scaler_pkg::IN_VACTIVE_D * scaler_pkg::VREP_D,
  parameter int H_SYNC   = scaler_pkg::H_SYNC_D,
  parameter int H_BACK   = scaler_pkg::H_BACK_D,
  parameter int H_FRONT  = scaler_pkg::H_FRONT_D,
  parameter int V_SYNC   = scaler_pkg::V_SYNC_D,
  parameter int V_BACK   = scaler_pkg::V_BACK_D,
  parameter int V_FRONT  = scaler_pkg::V_FRONT_D
) (
  input  logic               VCLK_i,
  input  logic               nRST_i,
  input  logic               run_i,
  output scaler_pkg::cnt_t   hcnt_o,
  output scaler_pkg::cnt_t   vcnt_o,
  output scaler_pkg::sync_t  sync_o
);

  localparam scaler_pkg::cnt_t H_END = scaler_pkg::cnt_t'(H_SYNC + H_BACK + H_ACTIVE + H_FRONT - 1);
  localparam scaler_pkg::cnt_t V_END = scaler_pkg::cnt_t'(V_SYNC + V_BACK + V_ACTIVE + V_FRONT - 1);

  localparam scaler_pkg::cnt_t HS_LEN   = scaler_pkg::cnt_t'(H_SYNC);
  localparam scaler_pkg::cnt_t VS_LEN   = scaler_pkg::cnt_t'(V_SYNC);
  localparam scaler_pkg::cnt_t DE_HSTART = scaler_pkg::cnt_t'(H_SYNC + H_BACK);
  localparam scaler_pkg::cnt_t DE_HSTOP  = scaler_pkg::cnt_t'(H_SYNC + H_BACK + H_ACTIVE);
  localparam scaler_pkg::cnt_t DE_VSTART = scaler_pkg::cnt_t'(V_SYNC + V_BACK);
  localparam scaler_pkg::cnt_t DE_VSTOP  = scaler_pkg::cnt_t'(V_SYNC + V_BACK + V_ACTIVE);

  logic h_end;
  scaler_pkg::sync_t raster;

  assign h_end = (hcnt_o == H_END);

  always_ff @(posedge VCLK_i or negedge nRST_i) begin
    if (!nRST_i) begin
      hcnt_o <= '0;
      vcnt_o <= '0;
    end else if (!run_i) begin  // parked at origin until triggered
      hcnt_o <= '0;
      vcnt_o <= '0;
    end else if (h_end) begin
      hcnt_o <= '0;
      vcnt_o <= (vcnt_o == V_END) ? '0 : vcnt_o + 1'b1;
    end else begin
      hcnt_o <= hcnt_o + 1'b1;
    end
  end

  // raster decode of the current counter state
  always_comb begin
    raster.hsync = (hcnt_o < HS_LEN);
    raster.vsync = (vcnt_o < VS_LEN);
    raster.de    = (hcnt_o >= DE_HSTART) && (hcnt_o < DE_HSTOP) &&
                   (vcnt_o >= DE_VSTART) && (vcnt_o < DE_VSTOP);
  end

  always_ff @(posedge VCLK_i or negedge nRST_i) begin
    if (!nRST_i)
      sync_o <= '0;
    else
      sync_o <= run_i ? raster : '0;  // one cycle behind the counters
  end

endmodule

/* src/line_buffer.sv */
`timescale 1ns/1ps

module line_buffer (
  input  logic                  VCLK_i,
  input  scaler_pkg::buf_wr_t   buf_wr_i,
  input  scaler_pkg::page_t     rd_page_i,
  input  scaler_pkg::buf_addr_t rd_addr_i,
  output scaler_pkg::pixel_t    rd_data_o
);

  localparam int PAGE_DEPTH = 2 ** $bits(scaler_pkg::buf_addr_t);
  localparam int DEPTH      = 3 * PAGE_DEPTH;

  // flat store, page in the upper address bits
  scaler_pkg::pixel_t mem [0:DEPTH-1];

  logic [$bits(scaler_pkg::page_t)+$bits(scaler_pkg::buf_addr_t)-1:0] wr_idx;
  logic [$bits(scaler_pkg::page_t)+$bits(scaler_pkg::buf_addr_t)-1:0] rd_idx;

  assign wr_idx = {buf_wr_i.page, buf_wr_i.addr};
  assign rd_idx = {rd_page_i, rd_addr_i};

  always_ff @(posedge VCLK_i) begin
    if (buf_wr_i.en)
      mem[wr_idx] <= buf_wr_i.data;
  end

  // registered read, old data on a same address collision
  always_ff @(posedge VCLK_i) begin
    rd_data_o <= mem[rd_idx];
  end

endmodule

/* src/input_capture.sv */
`timescale 1ns/1ps

module input_capture #(
  parameter int IN_HSTART  = scaler_pkg::IN_HSTART_D,
  parameter int IN_HACTIVE = scaler_pkg::IN_HACTIVE_D,
  parameter int IN_VSTART  = scaler_pkg::IN_VSTART_D,
  parameter int IN_VACTIVE = scaler_pkg::IN_VACTIVE_D,
  parameter int TRIG_LINES = scaler_pkg::TRIG_LINES_D
) (
  input  logic                  VCLK_i,
  input  logic                  nRST_i,
  input  scaler_pkg::video_in_t vdata_i,
  input  logic                  vdata_valid_i,
  input  logic                  scaler_nresync_i,
  input  scaler_pkg::page_t     rd_page_i,
  output scaler_pkg::buf_wr_t   buf_wr_o,
  output scaler_pkg::page_t     last_page_o,
  output logic                  run_o
);

  localparam scaler_pkg::cnt_t H_FIRST = scaler_pkg::cnt_t'(IN_HSTART);
  localparam scaler_pkg::cnt_t H_LAST  = scaler_pkg::cnt_t'(IN_HSTART + IN_HACTIVE - 1);
  localparam scaler_pkg::cnt_t V_FIRST = scaler_pkg::cnt_t'(IN_VSTART);
  localparam scaler_pkg::cnt_t V_LAST  = scaler_pkg::cnt_t'(IN_VSTART + IN_VACTIVE - 1);
  localparam scaler_pkg::cnt_t V_TRIG  = scaler_pkg::cnt_t'(TRIG_LINES);
  localparam scaler_pkg::buf_addr_t ADDR_LAST = scaler_pkg::buf_addr_t'(IN_HACTIVE - 1);

  logic nhs_q;
  logic nvs_q;
  logic line_start;
  logic frame_start;
  scaler_pkg::cnt_t hcnt_q;
  scaler_pkg::cnt_t vcnt_q;
  scaler_pkg::cnt_t h_cur;   // position of the sample on the bus now
  scaler_pkg::cnt_t v_cur;
  logic in_win;
  logic first_px;
  scaler_pkg::page_t free_page;
  scaler_pkg::page_t wr_page_q;
  logic wr_en_q;
  scaler_pkg::buf_addr_t wr_addr_q;
  scaler_pkg::pixel_t wr_data_q;
  logic armed_q;

  // the one page neither shown nor last completed
  function automatic scaler_pkg::page_t pick_free(input scaler_pkg::page_t a,
                                                   input scaler_pkg::page_t b);
    scaler_pkg::page_t p;
    if (a != 2'd0 && b != 2'd0)
      p = 2'd0;
    else if (a != 2'd1 && b != 2'd1)
      p = 2'd1;
    else
      p = 2'd2;
    return p;
  endfunction

  assign line_start  = vdata_valid_i & nhs_q & ~vdata_i.nhs;
  assign frame_start = vdata_valid_i & nvs_q & ~vdata_i.nvs;

  assign h_cur = line_start ? '0 : hcnt_q + 1'b1;
  assign v_cur = frame_start ? '0 : (line_start ? vcnt_q + 1'b1 : vcnt_q);

  assign in_win   = (h_cur >= H_FIRST) && (h_cur <= H_LAST) &&
                    (v_cur >= V_FIRST) && (v_cur <= V_LAST);
  assign first_px = in_win && (h_cur == H_FIRST);
  assign free_page = pick_free(last_page_o, rd_page_i);

  always_ff @(posedge VCLK_i or negedge nRST_i) begin
    if (!nRST_i) begin
      nhs_q  <= 1'b0;
      nvs_q  <= 1'b0;
      hcnt_q <= '0;
      vcnt_q <= '0;
    end else if (vdata_valid_i) begin  // stalls freeze everything here
      nhs_q  <= vdata_i.nhs;
      nvs_q  <= vdata_i.nvs;
      hcnt_q <= h_cur;
      vcnt_q <= v_cur;
    end
  end

  always_ff @(posedge VCLK_i or negedge nRST_i) begin
    if (!nRST_i) begin
      wr_en_q     <= 1'b0;
      wr_page_q   <= '0;
      last_page_o <= '0;
    end else begin
      wr_en_q <= vdata_valid_i && in_win;
      if (vdata_valid_i && first_px)
        wr_page_q <= free_page;  // held for the whole line
      if (wr_en_q && wr_addr_q == ADDR_LAST)
        last_page_o <= wr_page_q;
    end
  end

  always_ff @(posedge VCLK_i) begin
    if (vdata_valid_i && in_win) begin
      wr_addr_q <= scaler_pkg::buf_addr_t'(h_cur - H_FIRST);
      wr_data_q <= vdata_i.pixel;
    end
  end

  assign buf_wr_o = '{en: wr_en_q, page: wr_page_q, addr: wr_addr_q, data: wr_data_q};

  // start trigger, needs a fresh frame after reset or resync
  always_ff @(posedge VCLK_i or negedge nRST_i) begin
    if (!nRST_i) begin
      run_o   <= 1'b0;
      armed_q <= 1'b0;
    end else if (!scaler_nresync_i) begin
      run_o   <= 1'b0;
      armed_q <= 1'b0;
    end else begin
      if (frame_start)
        armed_q <= 1'b1;
      if (line_start && armed_q && v_cur == V_TRIG)
        run_o <= 1'b1;
    end
  end

endmodule

/* src/scaler_pkg.sv */
package scaler_pkg;

  typedef logic [23:0] pixel_t;    // r, g, b at 8 bits each
  typedef logic [11:0] cnt_t;      // h or v position
  typedef logic [9:0]  buf_addr_t; // pixel slot within a buffered line
  typedef logic [1:0]  page_t;     // line buffer page, only 0..2 in use

  // input video as delivered by the source
  typedef struct packed {
    logic   nvs;
    logic   nhs;
    pixel_t pixel;
  } video_in_t;

  typedef struct packed {
    logic hsync;
    logic vsync;
    logic de;
  } sync_t;

  // one write into the line buffer
  typedef struct packed {
    logic      en;
    page_t     page;
    buf_addr_t addr;
    pixel_t    data;
  } buf_wr_t;

  // input capture window
  localparam int IN_HSTART_D  = 6;
  localparam int IN_HACTIVE_D = 16;
  localparam int IN_VSTART_D  = 3;
  localparam int IN_VACTIVE_D = 8;
  localparam int TRIG_LINES_D = 6;  // input lines before output starts

  localparam int HREP_D = 2;
  localparam int VREP_D = 2;

  // output raster, short lines so several fit in one input line
  localparam int H_SYNC_D  = 4;
  localparam int H_BACK_D  = 6;
  localparam int H_FRONT_D = 4;
  localparam int V_SYNC_D  = 2;
  localparam int V_BACK_D  = 2;
  localparam int V_FRONT_D = 2;

endpackage
